//--- logic/ise_params.svh
`ifndef ISE_PARAMS_SVH
`define ISE_PARAMS_SVH

// Data path and register file sizes.
`define ISE_XLEN        32
`define ISE_NUM_CPR     16

// Custom major opcode in bits 6:0.
`define ISE_OPCODE      7'b0101011

// --------------------
// Pack width enables.
// --------------------
`define ISE_P32_EN      1'b1
`define ISE_P16_EN      1'b1
`define ISE_P8_EN       1'b1
`define ISE_P4_EN       1'b1
`define ISE_P2_EN       1'b1

`endif

//--- logic/ise_isa_pkg.sv
`default_nettype none

`include "ise_params.svh"

package ise_isa_pkg;

    // Data and register index types.
    typedef logic [`ISE_XLEN-1:0]             word_t;
    typedef logic [$clog2(`ISE_NUM_CPR)-1:0]  cpr_addr_t;
    typedef logic [4:0]                       gpr_addr_t;
    typedef logic [`ISE_NUM_CPR-1:0]          cpr_mask_t;
    typedef logic [3:0]                       shamt_t;
    typedef logic [15:0]                      imm16_t;

    // Function codes from bits 31:27.
    typedef enum logic [4:0] {
        FUNCT_MV2GPR  = 5'd0,
        FUNCT_MV2COP  = 5'd1,
        FUNCT_ADD_PX  = 5'd2,
        FUNCT_SUB_PX  = 5'd3,
        FUNCT_SLLI_PX = 5'd4,
        FUNCT_SRLI_PX = 5'd5,
        FUNCT_CMOV    = 5'd6,
        FUNCT_CMOVN   = 5'd7,
        FUNCT_LUI     = 5'd8,
        FUNCT_LLI     = 5'd9
    } funct_e;

    // Lane width code from bits {24,19,11}.
    typedef enum logic [2:0] {
        PW_32 = 3'b000,
        PW_16 = 3'b001,
        PW_8  = 3'b010,
        PW_4  = 3'b011,
        PW_2  = 3'b100
    } pack_width_e;

    typedef enum logic [2:0] {
        RES_SUCCESS    = 3'b000,
        RES_DECODE_EXC = 3'b010
    } result_code_e;

endpackage

`default_nettype wire

//--- logic/ise_pipe_pkg.sv
`default_nettype none

package ise_pipe_pkg;

    import ise_isa_pkg::*;

    // --------------------
    // Decode to execute.
    // --------------------
    typedef struct packed {
        logic         valid;
        funct_e       funct;
        cpr_addr_t    crd;
        cpr_addr_t    crs1;
        cpr_addr_t    crs2;
        gpr_addr_t    rd;
        shamt_t       shamt;
        imm16_t       imm16;
        pack_width_e  width;
        word_t        rs1;
        logic         invalid;
    } dec_op_t;

    // --------------------
    // Execute to result.
    // --------------------
    typedef struct packed {
        logic          valid;
        logic          cpr_wen;
        cpr_addr_t     cpr_addr;
        word_t         cpr_wdata;
        logic          gpr_wen;
        gpr_addr_t     gpr_addr;
        word_t         gpr_wdata;
        result_code_e  code;
    } exe_res_t;

endpackage

`default_nettype wire

//--- logic/ise_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ise_params.svh"

module ise_decode (
    input  wire logic                  g_clk,
    input  wire logic                  g_resetn,
    input  wire logic                  insn_valid,
    input  wire ise_isa_pkg::word_t    insn_enc,
    input  wire ise_isa_pkg::word_t    rs1_data,
    output ise_pipe_pkg::dec_op_t      dec_op
);

    import ise_isa_pkg::*;
    import ise_pipe_pkg::*;

    logic       opcode_ok;
    logic       funct_ok;
    logic       is_px;
    logic       pw_ok;
    logic [2:0] pw_code;
    dec_op_t    dec_d;
    dec_op_t    dec_q;
    logic       valid_q;

    assign pw_code   = {insn_enc[24], insn_enc[19], insn_enc[11]};
    assign opcode_ok = (insn_enc[6:0] == `ISE_OPCODE);
    assign funct_ok  = (insn_enc[31:27] <= 5'd9);
    assign is_px     = (insn_enc[31:27] >= 5'd2) && (insn_enc[31:27] <= 5'd5);

    // Lane width must be a known code and enabled.
    always_comb
    begin
        case (pw_code)
            3'b000:  pw_ok = `ISE_P32_EN;
            3'b001:  pw_ok = `ISE_P16_EN;
            3'b010:  pw_ok = `ISE_P8_EN;
            3'b011:  pw_ok = `ISE_P4_EN;
            3'b100:  pw_ok = `ISE_P2_EN;
            default: pw_ok = 1'b0;
        endcase
    end

    // Field slicing.
    always_comb
    begin
        dec_d         = '0;
        dec_d.valid   = 1'b1;
        dec_d.funct   = funct_e'(insn_enc[31:27]);
        dec_d.crd     = insn_enc[10:7];
        dec_d.crs1    = insn_enc[18:15];
        dec_d.crs2    = insn_enc[23:20];
        dec_d.rd      = insn_enc[11:7];
        dec_d.shamt   = insn_enc[23:20];
        dec_d.imm16   = insn_enc[26:11];
        dec_d.width   = pack_width_e'(pw_code);
        dec_d.rs1     = rs1_data;
        dec_d.invalid = !opcode_ok || !funct_ok || (is_px && !pw_ok);
    end

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
            valid_q <= 1'b0;
        else
            valid_q <= insn_valid;
    end

    always_ff @(posedge g_clk)
    begin
        if (insn_valid)
            dec_q <= dec_d;
    end

    always_comb
    begin
        dec_op       = dec_q;
        dec_op.valid = valid_q;
    end

    a_px_width_legal: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (dec_op.valid && !dec_op.invalid &&
         (dec_op.funct inside {FUNCT_ADD_PX, FUNCT_SUB_PX, FUNCT_SLLI_PX, FUNCT_SRLI_PX}))
        |-> (dec_op.width inside {PW_32, PW_16, PW_8, PW_4, PW_2}));

endmodule

`default_nettype wire

//--- logic/ise_packed_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ise_packed_alu (
    input  wire ise_isa_pkg::word_t        op_a,
    input  wire ise_isa_pkg::word_t        op_b,
    input  wire ise_isa_pkg::shamt_t       shamt,
    input  wire ise_isa_pkg::pack_width_e  width,
    input  wire ise_isa_pkg::funct_e       funct,
    output ise_isa_pkg::word_t             result
);

    import ise_isa_pkg::*;

    localparam int W = $bits(word_t);

    logic [5:0] lane_w;
    logic [4:0] lane_mask;
    logic       sub;
    word_t      sum;
    word_t      shl;
    word_t      shr;

    always_comb
    begin
        case (width)
            PW_16:   lane_w = 6'd16;
            PW_8:    lane_w = 6'd8;
            PW_4:    lane_w = 6'd4;
            PW_2:    lane_w = 6'd2;
            default: lane_w = 6'd32;
        endcase
    end

    assign lane_mask = 5'(lane_w - 6'd1);
    assign sub       = (funct == FUNCT_SUB_PX);

    // Ripple add, carry restarts at each lane base.
    always_comb
    begin : add_sub
        logic carry;
        logic b_bit;
        carry = sub;
        for (int i = 0; i < W; i++)
        begin
            if ((5'(i) & lane_mask) == 5'd0)
                carry = sub;
            b_bit  = op_b[i] ^ sub;
            sum[i] = op_a[i] ^ b_bit ^ carry;
            carry  = (op_a[i] & b_bit) | (carry & (op_a[i] ^ b_bit));
        end
    end

    // Source bit must stay inside the lane, otherwise zero fill.
    always_comb
    begin : shifts
        int offs;
        shl = '0;
        shr = '0;
        for (int i = 0; i < W; i++)
        begin
            offs = i & int'(lane_mask);
            if (offs >= int'(shamt))
                shl[i] = op_a[i - int'(shamt)];
            if (offs + int'(shamt) < int'(lane_w))
                shr[i] = op_a[i + int'(shamt)];
        end
    end

    always_comb
    begin
        case (funct)
            FUNCT_SLLI_PX: result = shl;
            FUNCT_SRLI_PX: result = shr;
            default:       result = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ise_execute.sv
`timescale 1ns/1ps
`default_nettype none

module ise_execute (
    input  wire ise_pipe_pkg::dec_op_t  dec_op,
    output ise_isa_pkg::cpr_addr_t      cpr_raddr_a,
    output ise_isa_pkg::cpr_addr_t      cpr_raddr_b,
    input  wire ise_isa_pkg::word_t     cpr_rdata_a,
    input  wire ise_isa_pkg::word_t     cpr_rdata_b,
    output ise_pipe_pkg::exe_res_t      exe_res
);

    import ise_isa_pkg::*;
    import ise_pipe_pkg::*;

    word_t alu_result;
    logic  cpr_wen;
    logic  gpr_wen;
    word_t wdata;

    // lui and lli merge into the old crd value.
    assign cpr_raddr_a = (dec_op.funct inside {FUNCT_LUI, FUNCT_LLI}) ? dec_op.crd : dec_op.crs1;
    assign cpr_raddr_b = dec_op.crs2;

    ise_packed_alu alu_inst (
        .op_a   (cpr_rdata_a),
        .op_b   (cpr_rdata_b),
        .shamt  (dec_op.shamt),
        .width  (dec_op.width),
        .funct  (dec_op.funct),
        .result (alu_result)
    );

    // --------------------
    // Write-back select.
    // --------------------
    always_comb
    begin
        cpr_wen = 1'b0;
        gpr_wen = 1'b0;
        wdata   = cpr_rdata_a;
        if (!dec_op.invalid)
        begin
            case (dec_op.funct)
                FUNCT_MV2GPR: gpr_wen = 1'b1;
                FUNCT_MV2COP:
                begin
                    cpr_wen = 1'b1;
                    wdata   = dec_op.rs1;
                end
                FUNCT_ADD_PX, FUNCT_SUB_PX, FUNCT_SLLI_PX, FUNCT_SRLI_PX:
                begin
                    cpr_wen = 1'b1;
                    wdata   = alu_result;
                end
                FUNCT_CMOV:   cpr_wen = (cpr_rdata_b == '0);
                FUNCT_CMOVN:  cpr_wen = (cpr_rdata_b != '0);
                FUNCT_LUI:
                begin
                    cpr_wen = 1'b1;
                    wdata   = {dec_op.imm16, cpr_rdata_a[15:0]};
                end
                FUNCT_LLI:
                begin
                    cpr_wen = 1'b1;
                    wdata   = {cpr_rdata_a[31:16], dec_op.imm16};
                end
                default: ;
            endcase
        end
    end

    always_comb
    begin
        exe_res           = '0;
        exe_res.valid     = dec_op.valid;
        exe_res.cpr_wen   = dec_op.valid && cpr_wen;
        exe_res.cpr_addr  = dec_op.crd;
        exe_res.cpr_wdata = wdata;
        exe_res.gpr_wen   = dec_op.valid && gpr_wen;
        exe_res.gpr_addr  = dec_op.rd;
        exe_res.gpr_wdata = wdata;
        exe_res.code      = dec_op.invalid ? RES_DECODE_EXC : RES_SUCCESS;
    end

endmodule

`default_nettype wire

//--- logic/ise_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "ise_params.svh"

module ise_result (
    input  wire logic                    g_clk,
    input  wire logic                    g_resetn,
    input  wire ise_isa_pkg::cpr_addr_t  cpr_raddr_a,
    input  wire ise_isa_pkg::cpr_addr_t  cpr_raddr_b,
    output ise_isa_pkg::word_t           cpr_rdata_a,
    output ise_isa_pkg::word_t           cpr_rdata_b,
    input  wire ise_pipe_pkg::exe_res_t  exe_res,
    output logic                         result_valid,
    output ise_isa_pkg::result_code_e    result_code,
    output ise_isa_pkg::cpr_mask_t       cprs_written,
    output logic                         rd_wen,
    output ise_isa_pkg::gpr_addr_t       rd_addr,
    output ise_isa_pkg::word_t           rd_data
);

    import ise_isa_pkg::*;
    import ise_pipe_pkg::*;

    word_t cprs [`ISE_NUM_CPR];

    // Combinational read, so a write at this edge is seen next cycle.
    assign cpr_rdata_a = cprs[cpr_raddr_a];
    assign cpr_rdata_b = cprs[cpr_raddr_b];

    // --------------------
    // CPR file.
    // --------------------
    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            for (int i = 0; i < `ISE_NUM_CPR; i++)
                cprs[i] <= '0;
        end
        else if (exe_res.cpr_wen)
        begin
            cprs[exe_res.cpr_addr] <= exe_res.cpr_wdata;
        end
    end

    // Outputs hold between instructions.
    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            result_valid <= 1'b0;
            result_code  <= RES_SUCCESS;
            cprs_written <= '0;
            rd_wen       <= 1'b0;
        end
        else
        begin
            result_valid <= exe_res.valid;
            if (exe_res.valid)
            begin
                result_code  <= exe_res.code;
                cprs_written <= exe_res.cpr_wen ? (cpr_mask_t'(1) << exe_res.cpr_addr) : '0;
                rd_wen       <= exe_res.gpr_wen;
            end
        end
    end

    always_ff @(posedge g_clk)
    begin
        if (exe_res.valid)
        begin
            rd_addr <= exe_res.gpr_addr;
            rd_data <= exe_res.gpr_wdata;
        end
    end

    a_fail_no_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (exe_res.valid && exe_res.code != RES_SUCCESS) |=> (!rd_wen && cprs_written == '0));

    a_one_dest: assert property (@(posedge g_clk) disable iff (!g_resetn)
        exe_res.valid |=> !(rd_wen && (cprs_written != '0)));

endmodule

`default_nettype wire

//--- logic/ise_top.sv
`timescale 1ns/1ps
`default_nettype none

module ise_top (
    input  wire logic                  g_clk,
    input  wire logic                  g_resetn,
    input  wire logic                  insn_valid,
    input  wire ise_isa_pkg::word_t    insn_enc,
    input  wire ise_isa_pkg::word_t    rs1_data,
    output logic                       result_valid,
    output ise_isa_pkg::result_code_e  result_code,
    output ise_isa_pkg::cpr_mask_t     cprs_written,
    output logic                       rd_wen,
    output ise_isa_pkg::gpr_addr_t     rd_addr,
    output ise_isa_pkg::word_t         rd_data
);

    import ise_isa_pkg::*;
    import ise_pipe_pkg::*;

    dec_op_t   dec_op;
    exe_res_t  exe_res;
    cpr_addr_t cpr_raddr_a;
    cpr_addr_t cpr_raddr_b;
    word_t     cpr_rdata_a;
    word_t     cpr_rdata_b;

    ise_decode decode_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .insn_valid (insn_valid),
        .insn_enc   (insn_enc),
        .rs1_data   (rs1_data),
        .dec_op     (dec_op)
    );

    ise_execute execute_inst (
        .dec_op      (dec_op),
        .cpr_raddr_a (cpr_raddr_a),
        .cpr_raddr_b (cpr_raddr_b),
        .cpr_rdata_a (cpr_rdata_a),
        .cpr_rdata_b (cpr_rdata_b),
        .exe_res     (exe_res)
    );

    ise_result result_inst (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpr_raddr_a  (cpr_raddr_a),
        .cpr_raddr_b  (cpr_raddr_b),
        .cpr_rdata_a  (cpr_rdata_a),
        .cpr_rdata_b  (cpr_rdata_b),
        .exe_res      (exe_res),
        .result_valid (result_valid),
        .result_code  (result_code),
        .cprs_written (cprs_written),
        .rd_wen       (rd_wen),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

//--- tests/tb_ise_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ise_top;

    import ise_isa_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int CLK_HALF  = 20;
    localparam int RST_CYCLES = 16;

    // Expected outputs of one instruction.
    typedef struct packed {
        logic [2:0]  code;
        logic        rd_wen;
        gpr_addr_t   rd_addr;
        word_t       rd_data;
        cpr_mask_t   cprs_written;
    } expect_t;

    logic          g_clk;
    logic          g_resetn;
    logic          insn_valid;
    word_t         insn_enc;
    word_t         rs1_data;
    logic          result_valid;
    result_code_e  result_code;
    cpr_mask_t     cprs_written;
    logic          rd_wen;
    gpr_addr_t     rd_addr;
    word_t         rd_data;

    word_t         enc_arr [MAX_LINES];
    word_t         rs1_arr [MAX_LINES];
    expect_t       exp_arr [MAX_LINES];
    expect_t       exp_q [$];
    int            num_lines;
    int            error_count;
    int            missing_count;
    int            result_count;
    integer        seed;
    logic          stim_loaded;

    ise_top ise_top_inst (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .insn_valid   (insn_valid),
        .insn_enc     (insn_enc),
        .rs1_data     (rs1_data),
        .result_valid (result_valid),
        .result_code  (result_code),
        .cprs_written (cprs_written),
        .rd_wen       (rd_wen),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    initial
    begin
        g_clk = 1'b0;
        forever
            #CLK_HALF g_clk = ~g_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // --------------------
    // Stimulus file.
    // --------------------
    task automatic load_stimulus();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_enc;
        logic [31:0] f_rs1;
        logic [31:0] f_code;
        logic [31:0] f_wen;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_mask;
        num_lines = 0;
        fd = $fopen("tests/ise_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tests/ise_stim.txt");
            return;
        end
        while (!$feof(fd) && num_lines < MAX_LINES)
        begin
            line = "";
            rc = $fgets(line, fd);
            // Comment and blank lines do not parse as seven fields.
            if (rc > 0 && $sscanf(line, "%h %h %h %h %h %h %h", f_enc, f_rs1, f_code,
                                  f_wen, f_addr, f_data, f_mask) == 7)
            begin
                enc_arr[num_lines]              = f_enc;
                rs1_arr[num_lines]              = f_rs1;
                exp_arr[num_lines].code         = f_code[2:0];
                exp_arr[num_lines].rd_wen       = f_wen[0];
                exp_arr[num_lines].rd_addr      = f_addr[4:0];
                exp_arr[num_lines].rd_data      = f_data;
                exp_arr[num_lines].cprs_written = f_mask[15:0];
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    // Main sequence.
    initial
    begin
        int idle;
        int drain;
        g_resetn      = 1'b0;
        insn_valid    = 1'b0;
        insn_enc      = '0;
        rs1_data      = '0;
        error_count   = 0;
        missing_count = 0;
        result_count  = 0;
        seed          = 74227;
        stim_loaded   = 1'b0;
        load_stimulus();
        stim_loaded = 1'b1;
        if (num_lines == 0)
        begin
            error_count++;
            $display("No instructions were read from the stimulus file");
        end
        repeat (RST_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_value("result_valid", 32'd0, 32'(result_valid));
        check_value("rd_wen", 32'd0, 32'(rd_wen));
        check_value("cprs_written", 32'd0, 32'(cprs_written));

        for (int n = 0; n < num_lines; n++)
        begin
            @(posedge g_clk);
            insn_valid <= 1'b1;
            insn_enc   <= enc_arr[n];
            rs1_data   <= rs1_arr[n];
            exp_q.push_back(exp_arr[n]);
            idle = $unsigned($random(seed)) % 3;
            repeat (idle)
            begin
                @(posedge g_clk);
                insn_valid <= 1'b0;
            end
        end
        @(posedge g_clk);
        insn_valid <= 1'b0;

        drain = 0;
        while (exp_q.size() != 0 && drain < 10)
        begin
            @(negedge g_clk);
            drain++;
        end
        missing_count = exp_q.size();
        if (missing_count != 0)
            $display("%0d expected results never appeared on result_valid", missing_count);

        $display("Results checked %0d, errors %0d, missing %0d",
                 result_count, error_count, missing_count);
        if (error_count == 0 && missing_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------
    // Result checker.
    // --------------------
    always @(negedge g_clk)
    begin : result_check
        expect_t e;
        if (g_resetn && result_valid)
        begin
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("A result appeared at %0t with no instruction outstanding", $time);
            end
            else
            begin
                e = exp_q.pop_front();
                result_count++;
                check_value("result_code", 32'(e.code), 32'(result_code));
                check_value("rd_wen", 32'(e.rd_wen), 32'(rd_wen));
                check_value("cprs_written", 32'(e.cprs_written), 32'(cprs_written));
                // The GPR port is only meaningful when it writes.
                if (e.rd_wen)
                begin
                    check_value("rd_addr", 32'(e.rd_addr), 32'(rd_addr));
                    check_value("rd_data", e.rd_data, rd_data);
                end
            end
        end
    end

    // Watchdog sized from the number of instructions.
    initial
    begin
        wait (stim_loaded);
        repeat (num_lines * 5 + 40) @(posedge g_clk);
        $display("Timeout, the run did not finish within %0d cycles", num_lines * 5 + 40);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/ise_isa_pkg.sv
logic/ise_pipe_pkg.sv
logic/ise_decode.sv
logic/ise_packed_alu.sv
logic/ise_execute.sv
logic/ise_result.sv
logic/ise_top.sv
tests/tb_ise_top.sv

//--- Bender.yml
package:
  name: ise_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/ise_isa_pkg.sv
      - logic/ise_pipe_pkg.sv
      - logic/ise_decode.sv
      - logic/ise_packed_alu.sv
      - logic/ise_execute.sv
      - logic/ise_result.sv
      - logic/ise_top.sv
  - target: test
    files:
      - tests/tb_ise_top.sv

//--- tests/ise_stim.txt
// Columns, all hex: insn_enc rs1_data result_code rd_wen rd_addr rd_data cprs_written
// rd_addr and rd_data are compared only when rd_wen is 1.
000180AB 00000000 0 1 01 00000000 0000
080000AB 12345678 0 0 00 00000000 0002
000082AB 00000000 0 1 05 12345678 0000
0800012B 7FFFFFFF 0 0 00 00000000 0004
080001AB 00000001 0 0 00 00000000 0008
0800022B FFFFFFFF 0 0 00 00000000 0010
// Packed add, sub and shifts, each read back.
103102AB 00000000 0 0 00 00000000 0020
000282AB 00000000 0 1 05 80000000 0000
10310B2B 00000000 0 0 00 00000000 0040
0003032B 00000000 0 1 06 7FFF0000 0000
101A03AB 00000000 0 0 00 00000000 0080
000383AB 00000000 0 1 07 11335577 0000
18488C2B 00000000 0 0 00 00000000 0100
0004042B 00000000 0 1 08 23456789 0000
191184AB 00000000 0 0 00 00000000 0200
000484AB 00000000 0 1 09 321CFED9 0000
203A052B 00000000 0 0 00 00000000 0400
0005052B 00000000 0 1 0A F8F8F8F8 0000
28408DAB 00000000 0 0 00 00000000 0800
000585AB 00000000 0 1 0B 01230567 0000
284A0E2B 00000000 0 0 00 00000000 1000
0006062B 00000000 0 1 0C 00000000 0000
// Conditional moves.
300086AB 00000000 0 0 00 00000000 2000
3020872B 00000000 0 0 00 00000000 0000
3831072B 00000000 0 0 00 00000000 4000
380087AB 00000000 0 0 00 00000000 0000
000686AB 00000000 0 1 0D 12345678 0000
0007072B 00000000 0 1 0E 7FFFFFFF 0000
000787AB 00000000 0 1 0F 00000000 0000
// Upper and lower half immediates.
455E68AB 00000000 0 0 00 00000000 0002
489AB92B 00000000 0 0 00 00000000 0004
000080AB 00000000 0 1 01 ABCD5678 0000
0001012B 00000000 0 1 02 7FFF1357 0000
// Invalid encodings leave CPR 3 alone.
080001AA DEADBEEF 2 0 00 00000000 0000
500001AB 00000000 2 0 00 00000000 0000
111089AB 00000000 2 0 00 00000000 0000
000181AB 00000000 0 1 03 00000001 0000
